// ==== design/rv_decode_cfg.svh ====
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// datapath width and integer register count.
`define RV_XLEN  32
`define RV_NREGS 32

// machine CSR addresses.
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342

// exception code for an environment call from machine mode.
`define RV_CAUSE_ECALL_M 32'd11

`endif

// ==== design/rv_decode_pkg.sv ====
package rv_decode_pkg;

    // major opcodes, bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        OP_NONE   = 7'b0000000, // the all-zero word is the pipeline bubble.
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,
        IMM_NONE
    } imm_kind_e;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_e;

    // the two CSR sources select how execute merges rs1 into the old CSR value.
    typedef enum logic [1:0] {SRC_B_IMM, SRC_B_REG, SRC_B_CSR_SET, SRC_B_CSR_WRITE} src_b_e;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module inst_decoder (
    input  logic [31:0]            inst,
    output rv_decode_pkg::alu_op_e   alu_op,
    output rv_decode_pkg::imm_kind_e imm_kind,
    output rv_decode_pkg::src_a_e    src_a,
    output rv_decode_pkg::src_b_e    src_b,
    output logic [4:0]             rd,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [2:0]             funct3,
    output logic                   reg_wen,
    output logic                   mem_wen,
    output logic                   mem_ren,
    output logic                   branch,
    output logic                   branch_invert,
    output logic                   jump,
    output logic                   ecall,
    output logic                   mret,
    output logic [3:0]             csr_wen_req,
    output logic [11:0]            csr_addr
);
    import rv_decode_pkg::*;

    opcode_e opcode;

    // shared by OP-IMM and OP; only the register form has a subtract.
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode   = opcode_e'(inst[6:0]);
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign csr_addr = inst[31:20];

    assign ecall = (inst == 32'h0000_0073);
    assign mret  = (inst == 32'h3020_0073);

    always_comb begin
        // the defaults describe a bubble whose result is zero.
        alu_op        = ALU_ADD;
        imm_kind      = IMM_NONE;
        src_a         = SRC_A_ZERO;
        src_b         = SRC_B_IMM;
        reg_wen       = 1'b0;
        mem_wen       = 1'b0;
        mem_ren       = 1'b0;
        branch        = 1'b0;
        branch_invert = 1'b0;
        jump          = 1'b0;
        case (opcode)
            OP_LUI: begin
                imm_kind = IMM_U;
                reg_wen  = 1'b1;
            end
            OP_AUIPC: begin
                imm_kind = IMM_U;
                src_a    = SRC_A_PC;
                reg_wen  = 1'b1;
            end
            OP_JAL: begin
                imm_kind = IMM_J;
                src_a    = SRC_A_PC;
                jump     = 1'b1;
                reg_wen  = 1'b1;
            end
            OP_JALR: begin
                imm_kind = IMM_I;
                src_a    = SRC_A_REG;
                jump     = 1'b1;
                reg_wen  = 1'b1;
            end
            OP_BRANCH: begin
                imm_kind = IMM_B;
                src_a    = SRC_A_REG;
                src_b    = SRC_B_REG;
                branch   = 1'b1;
                case (funct3[2:1])
                    2'b00:   alu_op = ALU_EQ;
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: alu_op = ALU_ADD;
                endcase
                // bne, bge and bgeu take the opposite of the compare result.
                branch_invert = (funct3 == 3'b001) || (funct3 == 3'b101) || (funct3 == 3'b111);
            end
            OP_LOAD: begin
                imm_kind = IMM_I;
                src_a    = SRC_A_REG;
                mem_ren  = 1'b1;
                reg_wen  = 1'b1;
            end
            OP_STORE: begin
                imm_kind = IMM_S;
                src_a    = SRC_A_REG;
                mem_wen  = 1'b1;
            end
            OP_IMM: begin
                imm_kind = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I; // slli and srli/srai.
                src_a    = SRC_A_REG;
                alu_op   = arith_op(funct3, inst[30], 1'b0);
                reg_wen  = 1'b1;
            end
            OP_REG: begin
                src_a   = SRC_A_REG;
                src_b   = SRC_B_REG;
                alu_op  = arith_op(funct3, inst[30], 1'b1);
                reg_wen = 1'b1;
            end
            OP_SYSTEM: begin
                imm_kind = IMM_I;
                src_a    = SRC_A_REG;
                reg_wen  = 1'b1;
                if (funct3 == 3'b001) begin
                    src_b = SRC_B_CSR_WRITE;
                end else if (funct3 == 3'b010) begin
                    src_b  = SRC_B_CSR_SET;
                    alu_op = ALU_OR; // csrrs ors rs1 into the old value.
                end
            end
            default: ;
        endcase
        assert (!(mem_wen && mem_ren))
            else $error("decoder raised both mem_wen and mem_ren");
    end

    // one write request bit per CSR, in writeback order mepc, mcause, mstatus, mtvec.
    always_comb begin
        csr_wen_req = 4'b0000;
        if (opcode == OP_SYSTEM && (funct3 == 3'b001 || funct3 == 3'b010)) begin
            case (csr_addr)
                `RV_CSR_MEPC:    csr_wen_req[0] = 1'b1;
                `RV_CSR_MCAUSE:  csr_wen_req[1] = 1'b1;
                `RV_CSR_MSTATUS: csr_wen_req[2] = 1'b1;
                `RV_CSR_MTVEC:   csr_wen_req[3] = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module imm_gen (
    input  logic [31:0]              inst,
    input  rv_decode_pkg::imm_kind_e imm_kind,
    output logic [`RV_XLEN-1:0]      imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (imm_kind)
            IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
            IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B: begin
                // branch offsets are in halfwords, so bit 0 is always clear.
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_U: imm = {inst[31:12], 12'b0};
            IMM_J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            IMM_SHAMT: imm = {27'b0, inst[24:20]}; // shift amount is unsigned.
            default:   imm = '0;
        endcase
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          wb_rd,
    input  logic [`RV_XLEN-1:0] wb_value,
    input  logic                wb_reg_wen,
    output logic [`RV_XLEN-1:0] rs1_value,
    output logic [`RV_XLEN-1:0] rs2_value,
    output logic [`RV_XLEN-1:0] a0_value
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_reg_wen && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_value; // x0 is never written, so it stays zero.
        end
    end

    // no bypass here. A write shows up on the read ports one cycle later.
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign a0_value  = regs[10];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1 != 5'd0 || rs1_value == '0) && (rs2 != 5'd0 || rs2_value == '0)
    ) else $error("x0 read back a nonzero value");

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module csr_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [11:0]         csr_addr,
    input  logic                ecall,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] wb_csr_value,
    input  logic [3:0]          wb_csr_wen,
    output logic [`RV_XLEN-1:0] csr_value,
    output logic [`RV_XLEN-1:0] mepc,
    output logic [`RV_XLEN-1:0] mtvec
);

    logic [`RV_XLEN-1:0] mstatus;
    logic [`RV_XLEN-1:0] mcause;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            // a trap in decode overrides a writeback write to the same CSR.
            if (ecall) begin
                mepc   <= pc;
                mcause <= `RV_CAUSE_ECALL_M;
            end else begin
                if (wb_csr_wen[0]) mepc   <= wb_csr_value;
                if (wb_csr_wen[1]) mcause <= wb_csr_value;
            end
            if (wb_csr_wen[2]) mstatus <= wb_csr_value;
            if (wb_csr_wen[3]) mtvec   <= wb_csr_value;
        end
    end

    always_comb begin
        case (csr_addr)
            `RV_CSR_MSTATUS: csr_value = mstatus;
            `RV_CSR_MTVEC:   csr_value = mtvec;
            `RV_CSR_MEPC:    csr_value = mepc;
            `RV_CSR_MCAUSE:  csr_value = mcause;
            default:         csr_value = '0; // unimplemented CSRs read as zero.
        endcase
    end

    ecall_sets_mcause: assert property (
        @(posedge clk) disable iff (!rst_n)
        ecall |=> (mcause == `RV_CAUSE_ECALL_M)
    ) else $error("mcause not set to the ecall code after a trap");

endmodule

// ==== design/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               inst,
    input  logic [31:0]               pc,
    input  logic                      stall,
    input  logic                      flush,
    input  logic [4:0]                wb_rd,
    input  logic [31:0]               wb_value,
    input  logic                      wb_reg_wen,
    input  logic [31:0]               wb_csr_value,
    input  logic [3:0]                wb_csr_wen,
    output logic [31:0]               pc_out,
    output logic [31:0]               inst_out,
    output logic [31:0]               imm,
    output logic [31:0]               rs1_value,
    output logic [31:0]               rs2_value,
    output logic [31:0]               a0_value,
    output logic [31:0]               csr_value,
    output logic [31:0]               mepc,
    output logic [31:0]               mtvec,
    output rv_decode_pkg::alu_op_e    alu_op,
    output rv_decode_pkg::imm_kind_e  imm_kind,
    output rv_decode_pkg::src_a_e     src_a,
    output rv_decode_pkg::src_b_e     src_b,
    output logic [4:0]                rd,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [2:0]                funct3,
    output logic                      reg_wen,
    output logic                      mem_wen,
    output logic                      mem_ren,
    output logic                      branch,
    output logic                      branch_invert,
    output logic                      jump,
    output logic                      ecall,
    output logic                      mret,
    output logic [3:0]                csr_wen_req
);

    logic [31:0] inst_q;
    logic [31:0] pc_q;
    logic [11:0] csr_addr;

    // flush wins over stall and turns the slot into a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (!stall) begin
            inst_q <= inst;
            pc_q   <= pc;
        end
    end

    assign inst_out = inst_q;
    assign pc_out   = pc_q;

    inst_decoder inst_decoder_inst (
        .inst          (inst_q),
        .alu_op        (alu_op),
        .imm_kind      (imm_kind),
        .src_a         (src_a),
        .src_b         (src_b),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .funct3        (funct3),
        .reg_wen       (reg_wen),
        .mem_wen       (mem_wen),
        .mem_ren       (mem_ren),
        .branch        (branch),
        .branch_invert (branch_invert),
        .jump          (jump),
        .ecall         (ecall),
        .mret          (mret),
        .csr_wen_req   (csr_wen_req),
        .csr_addr      (csr_addr)
    );

    imm_gen imm_gen_inst (
        .inst     (inst_q),
        .imm_kind (imm_kind),
        .imm      (imm)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .wb_rd      (wb_rd),
        .wb_value   (wb_value),
        .wb_reg_wen (wb_reg_wen),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .a0_value   (a0_value)
    );

    csr_file csr_file_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_addr     (csr_addr),
        .ecall        (ecall),
        .pc           (pc_q),
        .wb_csr_value (wb_csr_value),
        .wb_csr_wen   (wb_csr_wen),
        .csr_value    (csr_value),
        .mepc         (mepc),
        .mtvec        (mtvec)
    );

    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> (inst_out == '0)
    ) else $error("latched instruction not cleared after flush");

endmodule

// ==== dv/id_stage_tb.sv ====
`timescale 1ns/1ps
`include "rv_decode_cfg.svh"

module id_stage_tb;
    import rv_decode_pkg::*;

    localparam int NUM_RANDOM   = 2000;
    localparam int NUM_DIRECTED = 15;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int WATCHDOG_NS  = (NUM_RANDOM + NUM_DIRECTED) * CLK_PERIOD * 2
                                  + RESET_CYCLES * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        stall;
    logic        flush;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;
    logic        wb_reg_wen;
    logic [31:0] wb_csr_value;
    logic [3:0]  wb_csr_wen;

    logic [31:0] pc_out;
    logic [31:0] inst_out;
    logic [31:0] imm;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] a0_value;
    logic [31:0] csr_value;
    logic [31:0] mepc;
    logic [31:0] mtvec;
    alu_op_e     alu_op;
    imm_kind_e   imm_kind;
    src_a_e      src_a;
    src_b_e      src_b;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic        reg_wen;
    logic        mem_wen;
    logic        mem_ren;
    logic        branch;
    logic        branch_invert;
    logic        jump;
    logic        ecall;
    logic        mret;
    logic [3:0]  csr_wen_req;

    // the reference model holds the latch, the register file and the four CSRs.
    logic [31:0] m_inst;
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    // copy of what the DUT inputs hold until the next rising edge.
    logic [31:0] s_inst;
    logic [31:0] s_pc;
    logic        s_stall;
    logic        s_flush;
    logic [4:0]  s_rd;
    logic [31:0] s_value;
    logic        s_reg_wen;
    logic [31:0] s_csr_value;
    logic [3:0]  s_csr_wen;

    // expected decode of the latched word.
    alu_op_e     e_alu;
    imm_kind_e   e_kind;
    src_a_e      e_src_a;
    src_b_e      e_src_b;
    logic        e_reg_wen;
    logic        e_mem_wen;
    logic        e_mem_ren;
    logic        e_branch;
    logic        e_binv;
    logic        e_jump;
    logic        e_ecall;
    logic        e_mret;
    logic [3:0]  e_csr_req;
    logic [31:0] e_imm;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run timed out before all tests finished");
        $display("sim failed");
        $fatal(1, "timeout");
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic alu_op_cmp(input alu_op_e exp, input alu_op_e act);
        if (act !== exp) begin
            $display("** Error at %0t ns: alu_op expected %s, got %s",
                     $time, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic imm_kind_cmp(input imm_kind_e exp, input imm_kind_e act);
        if (act !== exp) begin
            $display("** Error at %0t ns: imm_kind expected %s, got %s",
                     $time, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic src_pair_cmp(input src_a_e exp_a, input src_b_e exp_b,
                                input src_a_e act_a, input src_b_e act_b);
        if (act_a !== exp_a || act_b !== exp_b) begin
            $display("** Error at %0t ns: src_a/src_b expected %s/%s, got %s/%s",
                     $time, exp_a.name(), exp_b.name(), act_a.name(), act_b.name());
            abort_run();
        end
    endtask

    task automatic flag_cmp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic word_cmp(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // shifts the field to the top and back down arithmetically.
    function automatic logic [31:0] sign_extend(input logic [31:0] v, input int bits);
        logic [31:0] shifted;
        shifted = v << (32 - bits);
        return $signed(shifted) >>> (32 - bits);
    endfunction

    function automatic logic [31:0] model_csr_read(input logic [11:0] addr);
        case (addr)
            `RV_CSR_MSTATUS: return m_mstatus;
            `RV_CSR_MTVEC:   return m_mtvec;
            `RV_CSR_MEPC:    return m_mepc;
            `RV_CSR_MCAUSE:  return m_mcause;
            default:         return 32'd0;
        endcase
    endfunction

    task automatic decode_model(input logic [31:0] w);
        opcode_e    op;
        logic [2:0] f3;
        logic       alt;
        op  = opcode_e'(w[6:0]);
        f3  = w[14:12];
        alt = w[30];
        e_reg_wen = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG,
                               OP_SYSTEM};
        e_mem_ren = (op == OP_LOAD);
        e_mem_wen = (op == OP_STORE);
        e_branch  = (op == OP_BRANCH);
        e_jump    = (op == OP_JAL) || (op == OP_JALR);
        e_binv    = e_branch && f3[0]; // the odd branch encodings are the negated compares.
        e_ecall   = (w == 32'h0000_0073);
        e_mret    = (w == 32'h3020_0073);
        case (op)
            OP_LUI, OP_AUIPC:            e_kind = IMM_U;
            OP_JAL:                      e_kind = IMM_J;
            OP_JALR, OP_LOAD, OP_SYSTEM: e_kind = IMM_I;
            OP_BRANCH:                   e_kind = IMM_B;
            OP_STORE:                    e_kind = IMM_S;
            OP_IMM:  e_kind = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_I;
            default: e_kind = IMM_NONE;
        endcase
        case (op)
            OP_AUIPC, OP_JAL: e_src_a = SRC_A_PC;
            OP_LUI, OP_NONE:  e_src_a = SRC_A_ZERO;
            default:          e_src_a = SRC_A_REG;
        endcase
        e_src_b = SRC_B_IMM;
        if (op == OP_BRANCH || op == OP_REG) e_src_b = SRC_B_REG;
        if (op == OP_SYSTEM && f3 == 3'd1) e_src_b = SRC_B_CSR_WRITE;
        if (op == OP_SYSTEM && f3 == 3'd2) e_src_b = SRC_B_CSR_SET;
        e_alu = ALU_ADD;
        if (op == OP_BRANCH) begin
            case (f3)
                3'd0, 3'd1: e_alu = ALU_EQ;
                3'd4, 3'd5: e_alu = ALU_SLT;
                3'd6, 3'd7: e_alu = ALU_SLTU;
                default:    e_alu = ALU_ADD;
            endcase
        end else if (op == OP_IMM || op == OP_REG) begin
            case (f3)
                3'd0: e_alu = (op == OP_REG && alt) ? ALU_SUB : ALU_ADD;
                3'd1: e_alu = ALU_SLL;
                3'd2: e_alu = ALU_SLT;
                3'd3: e_alu = ALU_SLTU;
                3'd4: e_alu = ALU_XOR;
                3'd5: e_alu = alt ? ALU_SRA : ALU_SRL;
                3'd6: e_alu = ALU_OR;
                default: e_alu = ALU_AND;
            endcase
        end else if (op == OP_SYSTEM && f3 == 3'd2) begin
            e_alu = ALU_OR;
        end
        e_csr_req = 4'b0000;
        if (op == OP_SYSTEM && (f3 == 3'd1 || f3 == 3'd2)) begin
            case (w[31:20])
                `RV_CSR_MEPC:    e_csr_req = 4'b0001;
                `RV_CSR_MCAUSE:  e_csr_req = 4'b0010;
                `RV_CSR_MSTATUS: e_csr_req = 4'b0100;
                `RV_CSR_MTVEC:   e_csr_req = 4'b1000;
                default:         e_csr_req = 4'b0000;
            endcase
        end
        case (e_kind)
            IMM_I:     e_imm = sign_extend(32'(w[31:20]), 12);
            IMM_S:     e_imm = sign_extend(32'({w[31:25], w[11:7]}), 12);
            IMM_B:     e_imm = sign_extend(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            IMM_U:     e_imm = {w[31:12], 12'h000};
            IMM_J:     e_imm = sign_extend(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            IMM_SHAMT: e_imm = 32'(w[24:20]);
            default:   e_imm = 32'd0;
        endcase
    endtask

    // the CSRs and registers update from the latch as it was before the edge.
    task automatic advance_model();
        if (m_inst == 32'h0000_0073) begin
            m_mepc   = m_pc;
            m_mcause = `RV_CAUSE_ECALL_M;
        end else begin
            if (s_csr_wen[0]) m_mepc = s_csr_value;
            if (s_csr_wen[1]) m_mcause = s_csr_value;
        end
        if (s_csr_wen[2]) m_mstatus = s_csr_value;
        if (s_csr_wen[3]) m_mtvec = s_csr_value;
        if (s_reg_wen && s_rd != 5'd0) m_regs[s_rd] = s_value;
        if (s_flush) begin
            m_inst = 32'd0;
            m_pc   = 32'd0;
        end else if (!s_stall) begin
            m_inst = s_inst;
            m_pc   = s_pc;
        end
    endtask

    task automatic outputs_cmp();
        decode_model(m_inst);
        alu_op_cmp(e_alu, alu_op);
        imm_kind_cmp(e_kind, imm_kind);
        src_pair_cmp(e_src_a, e_src_b, src_a, src_b);
        flag_cmp("reg_wen", e_reg_wen, reg_wen);
        flag_cmp("mem_wen", e_mem_wen, mem_wen);
        flag_cmp("mem_ren", e_mem_ren, mem_ren);
        flag_cmp("branch", e_branch, branch);
        flag_cmp("branch_invert", e_binv, branch_invert);
        flag_cmp("jump", e_jump, jump);
        flag_cmp("ecall", e_ecall, ecall);
        flag_cmp("mret", e_mret, mret);
        word_cmp("rd", 32'(m_inst[11:7]), 32'(rd));
        word_cmp("funct3", 32'(m_inst[14:12]), 32'(funct3));
        word_cmp("rs1", 32'(m_inst[19:15]), 32'(rs1));
        word_cmp("rs2", 32'(m_inst[24:20]), 32'(rs2));
        word_cmp("csr_wen_req", 32'(e_csr_req), 32'(csr_wen_req));
        word_cmp("imm", e_imm, imm);
        word_cmp("inst_out", m_inst, inst_out);
        word_cmp("pc_out", m_pc, pc_out);
        word_cmp("rs1_value", m_regs[m_inst[19:15]], rs1_value);
        word_cmp("rs2_value", m_regs[m_inst[24:20]], rs2_value);
        word_cmp("a0_value", m_regs[10], a0_value);
        word_cmp("csr_value", model_csr_read(m_inst[31:20]), csr_value);
        word_cmp("mepc", m_mepc, mepc);
        word_cmp("mtvec", m_mtvec, mtvec);
    endtask

    // each call updates the model at the edge, drives new inputs and checks at the falling edge.
    task automatic run_cycle(input logic [31:0] n_inst, input logic [31:0] n_pc,
                             input logic n_stall, input logic n_flush,
                             input logic [4:0] n_rd, input logic [31:0] n_value,
                             input logic n_reg_wen, input logic [31:0] n_csr_value,
                             input logic [3:0] n_csr_wen);
        @(posedge clk);
        advance_model();
        s_inst      = n_inst;
        s_pc        = n_pc;
        s_stall     = n_stall;
        s_flush     = n_flush;
        s_rd        = n_rd;
        s_value     = n_value;
        s_reg_wen   = n_reg_wen;
        s_csr_value = n_csr_value;
        s_csr_wen   = n_csr_wen;
        inst         <= n_inst;
        pc           <= n_pc;
        stall        <= n_stall;
        flush        <= n_flush;
        wb_rd        <= n_rd;
        wb_value     <= n_value;
        wb_reg_wen   <= n_reg_wen;
        wb_csr_value <= n_csr_value;
        wb_csr_wen   <= n_csr_wen;
        @(negedge clk);
        outputs_cmp();
    endtask

    task automatic present(input logic [31:0] n_inst, input logic [31:0] n_pc,
                           input logic n_stall, input logic n_flush);
        run_cycle(n_inst, n_pc, n_stall, n_flush, 5'd0, 32'd0, 1'b0, 32'd0, 4'b0000);
    endtask

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        logic [2:0]  f3;
        w = $urandom;
        case ($urandom_range(0, 11))
            0: w[6:0] = OP_LUI;
            1: w[6:0] = OP_AUIPC;
            2: w[6:0] = OP_JAL;
            3: begin
                w[6:0]   = OP_JALR;
                w[14:12] = 3'd0;
            end
            4: begin
                f3 = 3'($urandom_range(0, 5));
                if (f3 >= 3'd2) f3 = f3 + 3'd2; // skips the two reserved encodings.
                w[14:12] = f3;
                w[6:0]   = OP_BRANCH;
            end
            5: w[6:0] = OP_LOAD;
            6: w[6:0] = OP_STORE;
            7: begin
                w[6:0] = OP_IMM;
                if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[14] & w[30], 5'b00000};
            end
            8: begin
                w[6:0]   = OP_REG;
                w[30]    = w[30] && (w[14:12] == 3'd0 || w[14:12] == 3'd5);
                w[31]    = 1'b0;
                w[29:25] = 5'b00000;
            end
            9: begin
                w[6:0]   = OP_SYSTEM;
                w[14:12] = ($urandom_range(0, 1) == 1) ? 3'b001 : 3'b010;
                case ($urandom_range(0, 4))
                    0: w[31:20] = `RV_CSR_MSTATUS;
                    1: w[31:20] = `RV_CSR_MTVEC;
                    2: w[31:20] = `RV_CSR_MEPC;
                    3: w[31:20] = `RV_CSR_MCAUSE;
                    default: w[31:20] = 12'($urandom);
                endcase
            end
            10: w = ($urandom_range(0, 1) == 1) ? 32'h0000_0073 : 32'h3020_0073;
            default: w = 32'd0;
        endcase
        return w;
    endfunction

    initial begin
        logic [31:0] r_pc;
        logic [4:0]  r_rd;
        logic [3:0]  r_csr_wen;
        void'($urandom(32'h6260));
        rst_n        <= 1'b0;
        inst         <= 32'd0;
        pc           <= 32'd0;
        stall        <= 1'b0;
        flush        <= 1'b0;
        wb_rd        <= 5'd0;
        wb_value     <= 32'd0;
        wb_reg_wen   <= 1'b0;
        wb_csr_value <= 32'd0;
        wb_csr_wen   <= 4'b0000;
        {m_inst, m_pc, m_mstatus, m_mtvec, m_mepc, m_mcause} = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
        {s_inst, s_pc, s_stall, s_flush, s_rd, s_value} = '0;
        {s_reg_wen, s_csr_value, s_csr_wen} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r_pc      = $urandom;
            r_pc[1:0] = 2'b00;
            case ($urandom_range(0, 7))
                0:       r_rd = 5'd0;
                1:       r_rd = 5'd10;
                default: r_rd = 5'($urandom);
            endcase
            r_csr_wen = ($urandom_range(0, 3) == 0) ? 4'($urandom) : 4'b0000;
            run_cycle(random_inst(), r_pc, $urandom_range(0, 7) == 0,
                      $urandom_range(0, 15) == 0, r_rd, $urandom,
                      $urandom_range(0, 1) == 1, $urandom, r_csr_wen);
        end

        // ecall in decode while writeback writes mepc and mcause in the same cycle.
        present(32'h0000_0073, 32'h0000_1234, 1'b0, 1'b0);
        run_cycle(32'h3420_20f3, 32'h0000_1238, 1'b0, 1'b0, 5'd0, 32'd0, 1'b0,
                  32'hdead_beef, 4'b0011);
        present(32'h0000_0013, 32'h0000_123c, 1'b0, 1'b0);
        word_cmp("mepc", 32'h0000_1234, mepc);
        word_cmp("csr_value", `RV_CAUSE_ECALL_M, csr_value);
        run_cycle(32'h3050_2073, 32'h0000_1240, 1'b0, 1'b0, 5'd0, 32'd0, 1'b0,
                  32'h0000_0100, 4'b1000);
        present(32'h0000_0013, 32'h0000_1244, 1'b0, 1'b0);
        word_cmp("mtvec", 32'h0000_0100, mtvec);

        // stall holds the latch, then flush beats a simultaneous stall.
        present(32'h00a0_0513, 32'h0000_0200, 1'b0, 1'b0);
        present(32'h0000_0033, 32'h0000_0204, 1'b1, 1'b0);
        present(32'h0000_0033, 32'h0000_0204, 1'b1, 1'b1);
        word_cmp("inst_out", 32'h00a0_0513, inst_out);
        word_cmp("pc_out", 32'h0000_0200, pc_out);
        present(32'h0000_0033, 32'h0000_0208, 1'b0, 1'b0);
        word_cmp("inst_out", 32'd0, inst_out);
        flag_cmp("reg_wen", 1'b0, reg_wen);

        // x0 ignores writes and a0 follows x10.
        run_cycle(32'h0000_0013, 32'h0000_020c, 1'b0, 1'b0, 5'd0, 32'hffff_ffff, 1'b1,
                  32'd0, 4'b0000);
        run_cycle(32'h0000_0013, 32'h0000_0210, 1'b0, 1'b0, 5'd10, 32'hcafe_f00d, 1'b1,
                  32'd0, 4'b0000);
        present(32'h0000_0013, 32'h0000_0214, 1'b0, 1'b0);
        word_cmp("rs1_value", 32'd0, rs1_value);
        word_cmp("a0_value", 32'hcafe_f00d, a0_value);

        // mret only for its exact word.
        present(32'h3020_0073, 32'h0000_0218, 1'b0, 1'b0);
        present(32'h3020_00f3, 32'h0000_021c, 1'b0, 1'b0);
        flag_cmp("mret", 1'b1, mret);
        present(32'h0000_0013, 32'h0000_0220, 1'b0, 1'b0);
        flag_cmp("mret", 1'b0, mret);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/rv_decode_pkg.sv
design/inst_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/csr_file.sv
design/id_stage.sv
dv/id_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the decode-stage testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module id_stage_tb -Mdir obj_dir -f compile.f

# The simulator's exit status is not used. The printed result decides.
output=$(./obj_dir/Vid_stage_tb 2>&1 || true)
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
